/* bp_pkg.sv */
// shared widths, opcode, entry-kind and state enums, and index helper functions.
package bp_pkg;

    localparam int XLEN = 32;

    // riscv major opcodes seen by the predictor.
    typedef enum logic [6:0] {
        OP_ALU    = 7'b0110011,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } bp_opcode_e;

    typedef enum logic {
        KIND_BRANCH = 1'b0,
        KIND_JUMP   = 1'b1
    } bp_kind_e;

    typedef enum logic {
        ST_INIT = 1'b0,
        ST_RUN  = 1'b1
    } bp_state_e;

    // index width for n entries, never below one bit.
    function automatic int unsigned idx_bits(input int unsigned n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    function automatic int unsigned max_of(input int unsigned a, input int unsigned b);
        return (a > b) ? a : b;
    endfunction

    function automatic logic is_jump(input bp_opcode_e op);
        return (op == OP_JAL) || (op == OP_JALR);
    endfunction

endpackage

/* bp_upd_if.sv */
// update bus carrying one drained resolved branch from the queue to both tables.
interface bp_upd_if;
    import bp_pkg::*;

    logic             valid;
    logic [XLEN-1:0]  pc;
    bp_opcode_e       op;
    logic             taken;
    logic [XLEN-1:0]  target;

    modport src (
        output valid, pc, op, taken, target
    );

    modport sink (
        input valid, pc, op, taken, target
    );

endinterface

/* bp_ctrl_fsm.sv */
// controller FSM that runs the table sweep after reset and then enables normal operation.
module bp_ctrl_fsm (
    input  logic clk,
    input  logic rst_i,
    input  logic sweep_done_i,
    output logic sweep_en_o,
    output logic drain_en_o,
    output logic ready_o
);
    import bp_pkg::*;

    bp_state_e state_q;
    bp_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_INIT: begin
                if (sweep_done_i) begin
                    state_d = ST_RUN;
                end
            end
            // run is final until the next reset.
            ST_RUN: state_d = ST_RUN;
            default: state_d = ST_INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ST_INIT;
        end else begin
            state_q <= state_d;
        end
    end

    assign sweep_en_o = (state_q == ST_INIT);
    assign drain_en_o = (state_q == ST_RUN);
    assign ready_o    = (state_q == ST_RUN);

endmodule

/* bp_sweep_counter.sv */
// index counter that walks every table entry once during initialisation.
module bp_sweep_counter #(
    parameter int SWEEP_LEN = 32
) (
    input  logic                                      clk,
    input  logic                                      rst_i,
    input  logic                                      en_i,
    output logic [bp_pkg::idx_bits(SWEEP_LEN)-1:0]    idx_o,
    output logic                                      done_o
);
    import bp_pkg::*;

    localparam int W = idx_bits(SWEEP_LEN);

    logic [W-1:0] idx_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            idx_q <= '0;
        end else if (en_i) begin
            idx_q <= done_o ? '0 : idx_q + W'(1);
        end
    end

    assign idx_o  = idx_q;
    assign done_o = en_i && (idx_q == W'(SWEEP_LEN - 1));

endmodule

/* bp_update_queue.sv */
// credit-managed FIFO of resolved branch and jump updates from execute.
module bp_update_queue #(
    parameter int UPD_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        push_i,
    input  logic [bp_pkg::XLEN-1:0]     pc_i,
    input  logic [bp_pkg::XLEN-1:0]     target_i,
    input  bp_pkg::bp_opcode_e          op_i,
    input  logic                        taken_i,
    input  logic                        drain_en_i,
    output logic                        credit_o,
    bp_upd_if.src                       upd
);
    import bp_pkg::*;

    localparam int PTR_W = idx_bits(UPD_DEPTH);
    localparam int CNT_W = idx_bits(UPD_DEPTH + 1);

    logic [XLEN-1:0] pc_mem     [UPD_DEPTH];
    logic [XLEN-1:0] target_mem [UPD_DEPTH];
    bp_opcode_e      op_mem     [UPD_DEPTH];
    logic            taken_mem  [UPD_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    // the sender's credits guarantee room, so push is never refused.
    assign pop = drain_en_i && (count != '0);

    always_ff @(posedge clk) begin
        if (push_i) begin
            pc_mem[wr_ptr]     <= pc_i;
            target_mem[wr_ptr] <= target_i;
            op_mem[wr_ptr]     <= op_i;
            taken_mem[wr_ptr]  <= taken_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(UPD_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(UPD_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            count <= count + CNT_W'(push_i) - CNT_W'(pop);
        end
    end

    // head entry goes to the tables in the cycle it is popped.
    assign upd.valid  = pop;
    assign upd.pc     = pc_mem[rd_ptr];
    assign upd.op     = op_mem[rd_ptr];
    assign upd.taken  = taken_mem[rd_ptr];
    assign upd.target = target_mem[rd_ptr];
    assign credit_o   = pop;

endmodule

/* bp_gshare.sv */
// gshare direction predictor with global history register and 2-bit counter table.
module bp_gshare #(
    parameter int GHR_BITS = 5
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     sweep_en_i,
    input  logic [GHR_BITS-1:0]      sweep_idx_i,
    input  logic                     lookup_valid_i,
    input  logic [bp_pkg::XLEN-1:0]  lookup_pc_i,
    bp_upd_if.sink                   upd,
    output logic                     dir_taken_o
);
    import bp_pkg::*;

    localparam int PHT_SIZE = 1 << GHR_BITS;

    logic [1:0]          pht [PHT_SIZE];
    logic [GHR_BITS-1:0] ghr;
    logic [GHR_BITS-1:0] lk_idx;
    logic [GHR_BITS-1:0] up_idx;
    logic [1:0]          ctr;
    logic [1:0]          ctr_next;
    logic                br_upd;
    logic                dir_q;

    assign lk_idx = lookup_pc_i[GHR_BITS+1:2] ^ ghr;
    assign up_idx = upd.pc[GHR_BITS+1:2] ^ ghr;
    assign br_upd = upd.valid && (upd.op == OP_BRANCH);

    // saturating counter step.
    always_comb begin
        ctr      = pht[up_idx];
        ctr_next = ctr;
        if (upd.taken && (ctr != 2'b11)) begin
            ctr_next = ctr + 2'd1;
        end else if (!upd.taken && (ctr != 2'b00)) begin
            ctr_next = ctr - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (sweep_en_i) begin
            pht[sweep_idx_i] <= 2'b01;
        end else if (br_upd) begin
            pht[up_idx] <= ctr_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ghr <= '0;
        end else if (br_upd) begin
            ghr <= {ghr[GHR_BITS-2:0], upd.taken};
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid_i) begin
            dir_q <= pht[lk_idx][1];
        end
    end

    assign dir_taken_o = dir_q;

endmodule

/* bp_btb.sv */
// direct-mapped branch target buffer with registered lookup and final taken/target choice.
module bp_btb #(
    parameter int NUM_BTB_ENTRIES = 32
) (
    input  logic                                          clk,
    input  logic                                          rst_i,
    input  logic                                          sweep_en_i,
    input  logic [bp_pkg::idx_bits(NUM_BTB_ENTRIES)-1:0]  sweep_idx_i,
    input  logic                                          lookup_valid_i,
    input  logic [bp_pkg::XLEN-1:0]                       lookup_pc_i,
    bp_upd_if.sink                                        upd,
    input  logic                                          dir_taken_i,
    output logic                                          pred_valid_o,
    output logic                                          pred_taken_o,
    output logic [bp_pkg::XLEN-1:0]                       pred_target_o
);
    import bp_pkg::*;

    localparam int IDX_W = idx_bits(NUM_BTB_ENTRIES);
    localparam int TAG_W = XLEN - IDX_W - 2;

    logic             valid_mem  [NUM_BTB_ENTRIES];
    logic [TAG_W-1:0] tag_mem    [NUM_BTB_ENTRIES];
    logic [XLEN-1:0]  target_mem [NUM_BTB_ENTRIES];
    bp_kind_e         kind_mem   [NUM_BTB_ENTRIES];

    logic [IDX_W-1:0] lk_idx;
    logic [TAG_W-1:0] lk_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic             lk_accept;
    logic             wr_en;

    logic             pred_valid_q;
    logic             hit_q;
    bp_kind_e         kind_q;
    logic [XLEN-1:0]  target_q;
    logic [XLEN-1:0]  pc_q;
    logic             taken;

    assign lk_idx = lookup_pc_i[IDX_W+1:2];
    assign lk_tag = lookup_pc_i[XLEN-1:IDX_W+2];
    assign wr_idx = upd.pc[IDX_W+1:2];
    assign wr_tag = upd.pc[XLEN-1:IDX_W+2];

    // no lookups while the tables are being cleared.
    assign lk_accept = lookup_valid_i && !sweep_en_i;

    // not-taken branches never allocate.
    assign wr_en = upd.valid &&
                   (is_jump(upd.op) || ((upd.op == OP_BRANCH) && upd.taken));

    always_ff @(posedge clk) begin
        if (sweep_en_i) begin
            valid_mem[sweep_idx_i] <= 1'b0;
        end else if (wr_en) begin
            valid_mem[wr_idx]  <= 1'b1;
            tag_mem[wr_idx]    <= wr_tag;
            target_mem[wr_idx] <= upd.target;
            kind_mem[wr_idx]   <= is_jump(upd.op) ? KIND_JUMP : KIND_BRANCH;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pred_valid_q <= 1'b0;
        end else begin
            pred_valid_q <= lk_accept;
        end
    end

    // reads see the table as it was before this edge's write.
    always_ff @(posedge clk) begin
        if (lk_accept) begin
            hit_q    <= valid_mem[lk_idx] && (tag_mem[lk_idx] == lk_tag);
            kind_q   <= kind_mem[lk_idx];
            target_q <= target_mem[lk_idx];
            pc_q     <= lookup_pc_i;
        end
    end

    assign taken = pred_valid_q && hit_q && ((kind_q == KIND_JUMP) || dir_taken_i);

    assign pred_valid_o  = pred_valid_q;
    assign pred_taken_o  = taken;
    assign pred_target_o = taken ? target_q : pc_q + XLEN'(4);

endmodule

/* bp_top.sv */
// branch prediction unit top level wiring controller, sweep, queue, BTB and gshare.
module bp_top #(
    parameter int NUM_BTB_ENTRIES = 32,
    parameter int GHR_BITS        = 5,
    parameter int UPD_DEPTH       = 4
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     lookup_valid_i,
    input  logic [bp_pkg::XLEN-1:0]  lookup_pc_i,
    output logic                     pred_valid_o,
    output logic                     pred_taken_o,
    output logic [bp_pkg::XLEN-1:0]  pred_target_o,
    input  logic                     upd_valid_i,
    input  logic [bp_pkg::XLEN-1:0]  upd_pc_i,
    input  bp_pkg::bp_opcode_e       upd_op_i,
    input  logic                     upd_taken_i,
    input  logic [bp_pkg::XLEN-1:0]  upd_target_i,
    output logic                     upd_credit_o,
    output logic                     ready_o
);
    import bp_pkg::*;

    localparam int SWEEP_LEN = max_of(NUM_BTB_ENTRIES, 1 << GHR_BITS);
    localparam int SWEEP_W   = idx_bits(SWEEP_LEN);
    localparam int BTB_IDX_W = idx_bits(NUM_BTB_ENTRIES);

    logic               sweep_en;
    logic               sweep_done;
    logic               drain_en;
    logic [SWEEP_W-1:0] sweep_idx;
    logic               dir_taken;

    bp_upd_if upd_bus ();

    bp_ctrl_fsm u_ctrl (
        .clk          (clk),
        .rst_i        (rst_i),
        .sweep_done_i (sweep_done),
        .sweep_en_o   (sweep_en),
        .drain_en_o   (drain_en),
        .ready_o      (ready_o)
    );

    bp_sweep_counter #(.SWEEP_LEN(SWEEP_LEN)) u_sweep (
        .clk    (clk),
        .rst_i  (rst_i),
        .en_i   (sweep_en),
        .idx_o  (sweep_idx),
        .done_o (sweep_done)
    );

    bp_update_queue #(.UPD_DEPTH(UPD_DEPTH)) u_queue (
        .clk        (clk),
        .rst_i      (rst_i),
        .push_i     (upd_valid_i),
        .pc_i       (upd_pc_i),
        .target_i   (upd_target_i),
        .op_i       (upd_op_i),
        .taken_i    (upd_taken_i),
        .drain_en_i (drain_en),
        .credit_o   (upd_credit_o),
        .upd        (upd_bus.src)
    );

    // each table takes the low bits of the shared sweep index.
    bp_gshare #(.GHR_BITS(GHR_BITS)) u_gshare (
        .clk            (clk),
        .rst_i          (rst_i),
        .sweep_en_i     (sweep_en),
        .sweep_idx_i    (sweep_idx[GHR_BITS-1:0]),
        .lookup_valid_i (lookup_valid_i),
        .lookup_pc_i    (lookup_pc_i),
        .upd            (upd_bus.sink),
        .dir_taken_o    (dir_taken)
    );

    bp_btb #(.NUM_BTB_ENTRIES(NUM_BTB_ENTRIES)) u_btb (
        .clk            (clk),
        .rst_i          (rst_i),
        .sweep_en_i     (sweep_en),
        .sweep_idx_i    (sweep_idx[BTB_IDX_W-1:0]),
        .lookup_valid_i (lookup_valid_i),
        .lookup_pc_i    (lookup_pc_i),
        .upd            (upd_bus.sink),
        .dir_taken_i    (dir_taken),
        .pred_valid_o   (pred_valid_o),
        .pred_taken_o   (pred_taken_o),
        .pred_target_o  (pred_target_o)
    );

endmodule

/* bp_assertions.sv */
// concurrent checks on update queue occupancy and controller sequencing, bound into the design.
module bp_assertions #(
    parameter int CNT_W = 1,
    parameter int DEPTH = 1
) (
    input logic             clk,
    input logic             rst_i,
    input logic [CNT_W-1:0] count_i,
    input logic             push_i,
    input logic             sweep_done_i,
    input logic             drain_i,
    input logic             ready_i
);
    logic full;

    assign full = (count_i == CNT_W'(DEPTH));

    no_push_when_full: assert property (@(posedge clk) disable iff (rst_i) full |-> !push_i)
        else $error("update pushed while the queue holds %0d entries", DEPTH);

    // draining starts only in the cycle after the last sweep index.
    no_drain_in_init: assert property (@(posedge clk) disable iff (rst_i)
        drain_i |-> $past(drain_i) || $past(sweep_done_i))
        else $error("queue drained before table initialisation finished");

    // ready is sticky until the next reset.
    ready_stays_high: assert property (@(posedge clk) disable iff (rst_i) ready_i |=> ready_i)
        else $error("ready fell after initialisation");

endmodule

bind bp_update_queue bp_assertions #(.CNT_W(CNT_W), .DEPTH(UPD_DEPTH)) u_queue_checks (
    .clk          (clk),
    .rst_i        (rst_i),
    .count_i      (count),
    .push_i       (push_i),
    .sweep_done_i (1'b0),
    .drain_i      (1'b0),
    .ready_i      (1'b0)
);

bind bp_ctrl_fsm bp_assertions u_ctrl_checks (
    .clk          (clk),
    .rst_i        (rst_i),
    .count_i      (1'b0),
    .push_i       (1'b0),
    .sweep_done_i (sweep_done_i),
    .drain_i      (drain_en_o),
    .ready_i      (ready_o)
);

/* bp_tb.sv */
// testbench for bp_top with random stimulus, credit tracking, reference model and checks.
module bp_tb;
    import bp_pkg::*;

    localparam int NUM_BTB_ENTRIES = 32;
    localparam int GHR_BITS        = 5;
    localparam int UPD_DEPTH       = 4;
    localparam int PHT_SIZE        = 1 << GHR_BITS;
    localparam int SWEEP_LEN       = (NUM_BTB_ENTRIES > PHT_SIZE) ? NUM_BTB_ENTRIES : PHT_SIZE;
    localparam int IDX_W           = $clog2(NUM_BTB_ENTRIES);
    localparam int POOL            = 6;
    localparam int NUM_ROUNDS      = 300;
    // a round is at most a burst or a run of five branches plus a few lookups.
    localparam int ROUND_CYCLES    = 40;
    localparam int WATCHDOG_TIME   = (NUM_ROUNDS + 20) * ROUND_CYCLES * 10;

    logic            clk;
    logic            rst_i;
    logic            lookup_valid_i;
    logic [XLEN-1:0] lookup_pc_i;
    logic            pred_valid_o;
    logic            pred_taken_o;
    logic [XLEN-1:0] pred_target_o;
    logic            upd_valid_i;
    logic [XLEN-1:0] upd_pc_i;
    bp_opcode_e      upd_op_i;
    logic            upd_taken_i;
    logic [XLEN-1:0] upd_target_i;
    logic            upd_credit_o;
    logic            ready_o;

    // reference model of the tables.
    logic                  m_valid  [NUM_BTB_ENTRIES];
    logic [XLEN-IDX_W-3:0] m_tag    [NUM_BTB_ENTRIES];
    logic [XLEN-1:0]       m_target [NUM_BTB_ENTRIES];
    logic                  m_jump   [NUM_BTB_ENTRIES];
    logic [1:0]            m_pht    [PHT_SIZE];
    logic [GHR_BITS-1:0]   m_ghr;

    integer          seed = 62618;
    int              errors;
    int              credits;
    int              sent;
    int              returned;
    int              checked;
    int              cyc;
    logic            credit_seen;
    logic            ready_seen;
    logic            lk_pending;
    logic            exp_taken;
    logic [XLEN-1:0] exp_target;
    logic [XLEN-1:0] exp_pc;
    logic [XLEN-1:0] pool [POOL];

    bp_top #(
        .NUM_BTB_ENTRIES (NUM_BTB_ENTRIES),
        .GHR_BITS        (GHR_BITS),
        .UPD_DEPTH       (UPD_DEPTH)
    ) bp_top_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .lookup_valid_i (lookup_valid_i),
        .lookup_pc_i    (lookup_pc_i),
        .pred_valid_o   (pred_valid_o),
        .pred_taken_o   (pred_taken_o),
        .pred_target_o  (pred_target_o),
        .upd_valid_i    (upd_valid_i),
        .upd_pc_i       (upd_pc_i),
        .upd_op_i       (upd_op_i),
        .upd_taken_i    (upd_taken_i),
        .upd_target_i   (upd_target_i),
        .upd_credit_o   (upd_credit_o),
        .ready_o        (ready_o)
    );

    always #5 clk = ~clk;

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired at %0t before the test sequence finished", $time);
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic rand_bit();
        return rand_below(2) == 1;
    endfunction

    function automatic logic [XLEN-1:0] rand_word();
        return $unsigned($random(seed)) & 32'hffff_fffc;
    endfunction

    function automatic bp_opcode_e rand_op();
        case (rand_below(4))
            0: return OP_BRANCH;
            1: return OP_JAL;
            2: return OP_JALR;
            default: return OP_ALU;
        endcase
    endfunction

    // known pc, same index with another tag, or an unrelated pc.
    function automatic logic [XLEN-1:0] lookup_addr(input int unsigned k);
        case (rand_below(3))
            0: return pool[k];
            1: return pool[k] ^ (32'h80 << rand_below(XLEN - IDX_W - 2));
            default: return rand_word();
        endcase
    endfunction

    function automatic void model_predict(input logic [XLEN-1:0] pc, output logic taken,
                                          output logic [XLEN-1:0] target);
        logic [IDX_W-1:0] bi;
        logic             hit;
        logic             dir;
        bi     = pc[IDX_W+1:2];
        hit    = m_valid[bi] && (m_tag[bi] == pc[XLEN-1:IDX_W+2]);
        dir    = m_pht[pc[GHR_BITS+1:2] ^ m_ghr][1];
        taken  = hit && (m_jump[bi] || dir);
        target = taken ? m_target[bi] : pc + 32'd4;
    endfunction

    function automatic void model_update(input logic [XLEN-1:0] pc, input bp_opcode_e op,
                                         input logic taken, input logic [XLEN-1:0] target);
        logic [IDX_W-1:0]    bi;
        logic [GHR_BITS-1:0] pi;
        bi = pc[IDX_W+1:2];
        pi = pc[GHR_BITS+1:2] ^ m_ghr;
        if (op == OP_BRANCH) begin
            if (taken && (m_pht[pi] != 2'd3)) begin
                m_pht[pi] = m_pht[pi] + 2'd1;
            end else if (!taken && (m_pht[pi] != 2'd0)) begin
                m_pht[pi] = m_pht[pi] - 2'd1;
            end
            m_ghr = {m_ghr[GHR_BITS-2:0], taken};
        end
        if ((op == OP_JAL) || (op == OP_JALR) || ((op == OP_BRANCH) && taken)) begin
            m_valid[bi]  = 1'b1;
            m_tag[bi]    = pc[XLEN-1:IDX_W+2];
            m_target[bi] = target;
            m_jump[bi]   = (op != OP_BRANCH);
        end
    endfunction

    // one clock; a credit seen last cycle is counted at this edge.
    task automatic tick();
        @(posedge clk);
        if (credit_seen) begin
            credits++;
            returned++;
        end
        #1;
        cyc++;
        if (pred_valid_o !== lk_pending) begin
            errors++;
            $display("[ERROR] %0t: pred_valid_o is %b, expected %b", $time, pred_valid_o,
                     lk_pending);
        end else if (lk_pending) begin
            checked++;
            if (pred_taken_o !== exp_taken) begin
                errors++;
                $display("[ERROR] %0t: pc %h predicted taken %b, expected %b", $time, exp_pc,
                         pred_taken_o, exp_taken);
            end
            if (pred_target_o !== exp_target) begin
                errors++;
                $display("[ERROR] %0t: pc %h predicted target %h, expected %h", $time, exp_pc,
                         pred_target_o, exp_target);
            end
        end
        lk_pending = 1'b0;
        if (upd_credit_o && !ready_o) begin
            errors++;
            $display("[ERROR] %0t: credit returned during initialisation", $time);
        end
        if (ready_o && !ready_seen) begin
            ready_seen = 1'b1;
            if (cyc != SWEEP_LEN) begin
                errors++;
                $display("[ERROR] %0t: ready after %0d cycles, expected %0d", $time, cyc,
                         SWEEP_LEN);
            end
        end else if (!ready_o && ready_seen) begin
            errors++;
            $display("[ERROR] %0t: ready_o fell after initialisation", $time);
        end
        if (credits > UPD_DEPTH) begin
            errors++;
            $display("[ERROR] %0t: sender holds %0d credits, at most %0d", $time, credits,
                     UPD_DEPTH);
        end
        credit_seen    = upd_credit_o;
        lookup_valid_i = 1'b0;
        upd_valid_i    = 1'b0;
    endtask

    task automatic send_update(input logic [XLEN-1:0] pc, input bp_opcode_e op,
                               input logic taken, input logic [XLEN-1:0] target);
        while (credits == 0) begin
            tick();
        end
        upd_valid_i  = 1'b1;
        upd_pc_i     = pc;
        upd_op_i     = op;
        upd_taken_i  = taken;
        upd_target_i = target;
        credits--;
        sent++;
        model_update(pc, op, taken, target);
        tick();
    endtask

    // lookups wait until every sent update has drained into the tables.
    task automatic do_lookup(input logic [XLEN-1:0] pc);
        while (credits != UPD_DEPTH) begin
            tick();
        end
        model_predict(pc, exp_taken, exp_target);
        exp_pc         = pc;
        lookup_valid_i = 1'b1;
        lookup_pc_i    = pc;
        lk_pending     = 1'b1;
        tick();
    endtask

    task automatic random_round();
        int unsigned k;
        int unsigned n;
        logic        dir;
        k = rand_below(POOL);
        case (rand_below(8))
            0, 1: begin
                send_update(pool[k], rand_bit() ? OP_JAL : OP_JALR, 1'b1, rand_word());
                do_lookup(pool[k]);
                do_lookup(pool[k] ^ 32'h8000_0000);
            end
            2, 3: begin
                dir = rand_bit();
                n   = 1 + rand_below(5);
                repeat (n) send_update(pool[k], OP_BRANCH, dir, rand_word());
                do_lookup(pool[k]);
            end
            4: begin
                send_update(pool[k], OP_ALU, rand_bit(), rand_word());
                do_lookup(pool[k]);
            end
            5: begin
                repeat (UPD_DEPTH) send_update(pool[rand_below(POOL)], rand_op(), rand_bit(),
                                               rand_word());
            end
            default: begin
                n = 1 + rand_below(4);
                repeat (n) do_lookup(lookup_addr(rand_below(POOL)));
            end
        endcase
    endtask

    initial begin
        clk            = 1'b0;
        rst_i          = 1'b1;
        lookup_valid_i = 1'b0;
        lookup_pc_i    = '0;
        upd_valid_i    = 1'b0;
        upd_pc_i       = '0;
        upd_op_i       = OP_ALU;
        upd_taken_i    = 1'b0;
        upd_target_i   = '0;
        credits        = UPD_DEPTH;
        credit_seen    = 1'b0;
        ready_seen     = 1'b0;
        lk_pending     = 1'b0;
        m_ghr          = '0;
        for (int i = 0; i < NUM_BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        for (int i = 0; i < PHT_SIZE; i++) begin
            m_pht[i] = 2'b01;
        end
        for (int i = 0; i < POOL; i++) begin
            pool[i] = rand_word();
        end
        repeat (8) @(posedge clk);
        #1;
        rst_i = 1'b0;
        cyc   = 0;
        if ((ready_o !== 1'b0) || (pred_valid_o !== 1'b0) || (upd_credit_o !== 1'b0)) begin
            errors++;
            $display("[ERROR] %0t: outputs not idle after reset", $time);
        end
        // these wait in the queue until the sweep ends.
        for (int i = 0; i < UPD_DEPTH; i++) begin
            send_update(pool[i], rand_op(), rand_bit(), rand_word());
        end
        while (!ready_seen) begin
            tick();
        end
        repeat (8) do_lookup(rand_word());
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            random_round();
        end
        while (credits != UPD_DEPTH) begin
            tick();
        end
        if (returned != sent) begin
            errors++;
            $display("[ERROR] %0t: %0d credit pulses for %0d updates", $time, returned, sent);
        end
        $display("errors %0d, lookups checked %0d, updates sent %0d, credits returned %0d",
                 errors, checked, sent, returned);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
bp_pkg.sv
bp_upd_if.sv
bp_ctrl_fsm.sv
bp_sweep_counter.sv
bp_update_queue.sv
bp_gshare.sv
bp_btb.sv
bp_top.sv
bp_assertions.sv
bp_tb.sv

/* Makefile */
VERILATOR  := verilator
TOP        := bp_tb
FILELIST   := compile.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
